/* Bender.yml */
package:
  name: md_top

sources:
  - files:
      - common/md_pkg.sv
      - common/alu_pkg.sv
      - common/adder_if.sv
      - multdiv/multdiv_slow.sv
      - src/md_alu.sv
      - src/md_issue.sv
      - src/md_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_md_top.sv

/* common/adder_if.sv */
// ====================
// shared adder bus between the serial unit and the ALU
// requester drives the operands, adder returns the sums
// ====================
`default_nettype none

interface adder_if;

  import md_pkg::*;
  import alu_pkg::*;

  logic [AdderWidth-1:0]    operand_a;
  logic [AdderWidth-1:0]    operand_b;
  // raw sum of both operands with carry out
  logic [AdderExtWidth-1:0] adder_ext;
  // word result with the carry-in bit dropped
  logic [MdDataWidth-1:0]   adder_result;
  logic                     equal_to_zero;

  modport requester (
    output operand_a,
    output operand_b,
    input  adder_ext,
    input  adder_result,
    input  equal_to_zero
  );

  modport adder (
    input  operand_a,
    input  operand_b,
    output adder_ext,
    output adder_result,
    output equal_to_zero
  );

endinterface

`default_nettype wire

/* common/alu_pkg.sv */
// ====================
// widths of the shared adder and the direct add/sub operations
// ====================
`default_nettype none

package alu_pkg;

  // 32-bit word plus the carry-in bit at the bottom
  localparam int unsigned AdderWidth    = 33;
  // extended sum keeps the carry out on top
  localparam int unsigned AdderExtWidth = AdderWidth + 1;

  // direct mode operation when no multiply or divide is running
  typedef enum logic {
    ALU_ADD,
    ALU_SUB
  } alu_op_e;

endpackage

`default_nettype wire

/* common/md_pkg.sv */
// ====================
// operation codes, sign mode and word widths shared by the
// issue stage, the serial multiply/divide unit and the top level
// ====================
`default_nettype none

package md_pkg;

  // operand and result word width
  localparam int unsigned MdDataWidth = 32;
  // sign-extended operand width used inside the serial unit
  localparam int unsigned MdExtWidth  = MdDataWidth + 1;

  typedef enum logic [2:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM,
    MD_OP_ADD,
    MD_OP_SUB
  } md_op_e;

  // bit 0 marks operand a signed, bit 1 marks operand b signed
  typedef logic [1:0] sign_mode_t;

  typedef enum logic [1:0] {
    KIND_ALU,
    KIND_MUL,
    KIND_DIV
  } md_kind_e;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+verification
common/md_pkg.sv
common/alu_pkg.sv
common/adder_if.sv
multdiv/multdiv_slow.sv
src/md_alu.sv
src/md_issue.sv
src/md_top.sv
verification/tb_md_top.sv

/* multdiv/multdiv_slow.sv */
// ====================
// serial Baugh-Wooley multiplier and restoring long divider
// borrows the shared ALU adder, holds while an enable is high
// ====================
`default_nettype none

module multdiv_slow #(
  parameter int unsigned NumIter = 31
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             mult_en_i,
  input  logic                             div_en_i,
  input  md_pkg::md_op_e                   operator_i,
  input  md_pkg::sign_mode_t               sign_mode_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_a_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_b_i,
  adder_if.requester                       adder_bus,
  output logic [md_pkg::MdDataWidth-1:0]   result_o,
  output logic                             valid_o
);

  import md_pkg::*;

  localparam int unsigned CntWidth = $clog2(NumIter + 1);

  typedef enum logic [2:0] {
    MD_IDLE,
    MD_ABS_A,
    MD_ABS_B,
    MD_COMP,
    MD_LAST,
    MD_CHANGE_SIGN,
    MD_FINISH
  } md_fsm_e;

  md_fsm_e                 md_state_q, md_state_d;
  logic [CntWidth-1:0]     iter_q, iter_d, iter_m1;
  logic [MdExtWidth-1:0]   accum_q, accum_d;
  logic [MdExtWidth-1:0]   op_a_shift_q, op_a_shift_d;
  logic [MdExtWidth-1:0]   op_b_shift_q, op_b_shift_d;
  logic [MdDataWidth-1:0]  numer_q, numer_d;
  logic [MdExtWidth-1:0]   op_a_ext, op_b_ext;
  logic [MdExtWidth-1:0]   res_adder_l, res_adder_h;
  logic [MdExtWidth-1:0]   pp, pp_last;
  logic [MdExtWidth-1:0]   one_shift;
  logic [MdExtWidth-1:0]   next_rem, next_quot;
  logic [MdDataWidth-1:0]  b_0;
  logic                    sign_a, sign_b;
  logic                    is_ge, is_mul;
  logic                    div_change_sign, rem_change_sign;

  // low window is the plain sum, high window is the sum shifted right
  assign res_adder_l = adder_bus.adder_ext[MdExtWidth-1:0];
  assign res_adder_h = adder_bus.adder_ext[MdExtWidth:1];

  assign sign_a   = op_a_i[MdDataWidth-1] & sign_mode_i[0];
  assign sign_b   = op_b_i[MdDataWidth-1] & sign_mode_i[1];
  assign op_a_ext = {sign_a, op_a_i};
  assign op_b_ext = {sign_b, op_b_i};

  assign div_change_sign = sign_a ^ sign_b;
  assign rem_change_sign = sign_a;
  assign is_mul          = (operator_i == MD_OP_MULL) || (operator_i == MD_OP_MULH);

  // Baugh-Wooley partial products, the top row is inverted except on the last step
  assign b_0     = {MdDataWidth{op_b_shift_q[0]}};
  assign pp      = {~(op_a_shift_q[MdDataWidth] & op_b_shift_q[0]),
                    op_a_shift_q[MdDataWidth-1:0] & b_0};
  assign pp_last = {op_a_shift_q[MdDataWidth] & op_b_shift_q[0],
                    ~(op_a_shift_q[MdDataWidth-1:0] & b_0)};

  // remainder minus divisor is non-negative when the adder does not go negative
  assign is_ge = ((accum_q[MdDataWidth-1] ^ op_b_shift_q[MdDataWidth-1]) == 1'b0) ?
                 (res_adder_h[MdDataWidth-1] == 1'b0) : accum_q[MdDataWidth-1];

  assign one_shift = {{MdDataWidth{1'b0}}, 1'b1} << iter_q;
  assign iter_m1   = iter_q - 1'b1;
  assign next_rem  = is_ge ? res_adder_h : accum_q;
  assign next_quot = is_ge ? (op_a_shift_q | one_shift) : op_a_shift_q;

  // adder operand selection and result
  always_comb begin
    adder_bus.operand_a = accum_q;
    adder_bus.operand_b = pp;
    result_o            = div_en_i ? accum_q[MdDataWidth-1:0] : res_adder_l[MdDataWidth-1:0];

    unique case (operator_i)
      MD_OP_MULL: begin
        adder_bus.operand_b = pp;
      end
      MD_OP_MULH: begin
        adder_bus.operand_b = (md_state_q == MD_LAST) ? pp_last : pp;
      end
      default: begin
        unique case (md_state_q)
          MD_IDLE, MD_ABS_B: begin
            // 0 - b, also gives the zero divisor check in idle
            adder_bus.operand_a = {{MdDataWidth{1'b0}}, 1'b1};
            adder_bus.operand_b = {~op_b_i, 1'b1};
          end
          MD_ABS_A: begin
            adder_bus.operand_a = {{MdDataWidth{1'b0}}, 1'b1};
            adder_bus.operand_b = {~op_a_i, 1'b1};
          end
          MD_CHANGE_SIGN: begin
            adder_bus.operand_a = {{MdDataWidth{1'b0}}, 1'b1};
            adder_bus.operand_b = {~accum_q[MdDataWidth-1:0], 1'b1};
          end
          default: begin
            // partial remainder minus divisor
            adder_bus.operand_a = {accum_q[MdDataWidth-1:0], 1'b1};
            adder_bus.operand_b = {~op_b_shift_q[MdDataWidth-1:0], 1'b1};
          end
        endcase
      end
    endcase
  end

  always_comb begin
    md_state_d   = md_state_q;
    iter_d       = iter_q;
    accum_d      = accum_q;
    op_a_shift_d = op_a_shift_q;
    op_b_shift_d = op_b_shift_q;
    numer_d      = numer_q;

    if (mult_en_i || div_en_i) begin
      unique case (md_state_q)
        MD_IDLE: begin
          unique case (operator_i)
            MD_OP_MULL: begin
              op_a_shift_d = op_a_ext << 1;
              accum_d      = {~(op_a_ext[MdDataWidth] & op_b_i[0]),
                              op_a_ext[MdDataWidth-1:0] & {MdDataWidth{op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              md_state_d   = MD_COMP;
            end
            MD_OP_MULH: begin
              op_a_shift_d = op_a_ext;
              accum_d      = {1'b1, ~(op_a_ext[MdDataWidth] & op_b_i[0]),
                              op_a_ext[MdDataWidth-1:1] & {(MdDataWidth-1){op_b_i[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              md_state_d   = MD_COMP;
            end
            MD_OP_DIV: begin
              // quotient for a zero divisor
              accum_d    = {MdExtWidth{1'b1}};
              md_state_d = adder_bus.equal_to_zero ? MD_FINISH : MD_ABS_A;
            end
            default: begin
              // remainder for a zero divisor
              accum_d    = op_a_ext;
              md_state_d = adder_bus.equal_to_zero ? MD_FINISH : MD_ABS_A;
            end
          endcase
          iter_d = CntWidth'(NumIter);
        end

        MD_ABS_A: begin
          op_a_shift_d = '0;
          numer_d      = sign_a ? adder_bus.adder_result : op_a_i;
          md_state_d   = MD_ABS_B;
        end

        MD_ABS_B: begin
          // first remainder bit is the numerator msb
          accum_d      = {{MdDataWidth{1'b0}}, numer_q[MdDataWidth-1]};
          op_b_shift_d = sign_b ? {1'b0, adder_bus.adder_result} : {1'b0, op_b_i};
          md_state_d   = MD_COMP;
        end

        MD_COMP: begin
          iter_d = iter_m1;
          unique case (operator_i)
            MD_OP_MULL: begin
              accum_d      = res_adder_l;
              op_a_shift_d = op_a_shift_q << 1;
              op_b_shift_d = op_b_shift_q >> 1;
            end
            MD_OP_MULH: begin
              accum_d      = res_adder_h;
              op_b_shift_d = op_b_shift_q >> 1;
            end
            default: begin
              accum_d      = {next_rem[MdDataWidth-1:0], numer_q[iter_m1]};
              op_a_shift_d = next_quot;
            end
          endcase
          md_state_d = (iter_q == CntWidth'(1)) ? MD_LAST : MD_COMP;
        end

        MD_LAST: begin
          unique case (operator_i)
            MD_OP_MULL, MD_OP_MULH: begin
              accum_d    = res_adder_l;
              md_state_d = MD_IDLE;
            end
            MD_OP_DIV: begin
              accum_d    = next_quot;
              md_state_d = MD_CHANGE_SIGN;
            end
            default: begin
              accum_d    = {1'b0, next_rem[MdDataWidth-1:0]};
              md_state_d = MD_CHANGE_SIGN;
            end
          endcase
        end

        MD_CHANGE_SIGN: begin
          md_state_d = MD_FINISH;
          if ((operator_i == MD_OP_DIV) ? div_change_sign : rem_change_sign) begin
            accum_d = {1'b0, adder_bus.adder_result};
          end
        end

        MD_FINISH: begin
          md_state_d = MD_IDLE;
        end

        default: begin
          md_state_d = MD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      md_state_q <= MD_IDLE;
      iter_q     <= '0;
    end else begin
      md_state_q <= md_state_d;
      iter_q     <= iter_d;
    end
  end

  always_ff @(posedge clk_i) begin
    accum_q      <= accum_d;
    op_a_shift_q <= op_a_shift_d;
    op_b_shift_q <= op_b_shift_d;
    numer_q      <= numer_d;
  end

  // multiply ends in the last step, divide in the finish state
  assign valid_o = (md_state_q == MD_FINISH) || ((md_state_q == MD_LAST) && is_mul);

endmodule

`default_nettype wire

/* src/md_alu.sv */
// ====================
// shared 33-bit adder with zero detect
// serves the serial unit while it runs, else direct add/sub
// ====================
`default_nettype none

module md_alu (
  input  logic                             mult_en_i,
  input  logic                             div_en_i,
  input  alu_pkg::alu_op_e                 alu_op_i,
  input  logic [md_pkg::MdDataWidth-1:0]   alu_a_i,
  input  logic [md_pkg::MdDataWidth-1:0]   alu_b_i,
  adder_if.adder                           adder_bus,
  output logic [md_pkg::MdDataWidth-1:0]   alu_result_o
);

  import alu_pkg::*;

  logic [AdderWidth-1:0]    adder_in_a, adder_in_b;
  logic [AdderExtWidth-1:0] adder_sum;
  logic [AdderWidth-2:0]    adder_word;

  always_comb begin
    if (mult_en_i || div_en_i) begin
      adder_in_a = adder_bus.operand_a;
      adder_in_b = adder_bus.operand_b;
    end else begin
      // low bit carries in the +1 of the two's complement on subtract
      adder_in_a = {alu_a_i, 1'b1};
      adder_in_b = (alu_op_i == ALU_SUB) ? {~alu_b_i, 1'b1} : {alu_b_i, 1'b0};
    end
  end

  assign adder_sum  = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_word = adder_sum[AdderWidth-1:1];

  assign adder_bus.adder_ext     = adder_sum;
  assign adder_bus.adder_result  = adder_word;
  assign adder_bus.equal_to_zero = (adder_word == '0);
  assign alu_result_o            = adder_word;

endmodule

`default_nettype wire

/* src/md_issue.sv */
// ====================
// issue stage, latches one request at a time, raises the
// matching enable and returns the result with a done pulse
// ====================
`default_nettype none

module md_issue (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  md_pkg::md_op_e                   op_i,
  input  md_pkg::sign_mode_t               sign_mode_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_a_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_b_i,
  input  logic                             md_valid_i,
  input  logic [md_pkg::MdDataWidth-1:0]   md_result_i,
  input  logic [md_pkg::MdDataWidth-1:0]   alu_result_i,
  output logic                             mult_en_o,
  output logic                             div_en_o,
  output md_pkg::md_op_e                   operator_o,
  output md_pkg::sign_mode_t               sign_mode_o,
  output logic [md_pkg::MdDataWidth-1:0]   md_a_o,
  output logic [md_pkg::MdDataWidth-1:0]   md_b_o,
  output alu_pkg::alu_op_e                 alu_op_o,
  output logic [md_pkg::MdDataWidth-1:0]   alu_a_o,
  output logic [md_pkg::MdDataWidth-1:0]   alu_b_o,
  output logic                             busy_o,
  output logic                             done_o,
  output logic [md_pkg::MdDataWidth-1:0]   result_o
);

  import md_pkg::*;
  import alu_pkg::*;

  md_kind_e               req_kind;
  logic                   accept, md_finish;
  logic                   busy_q, done_q, alu_pend_q;
  logic                   mult_en_q, div_en_q;
  md_op_e                 op_q;
  sign_mode_t             sign_q;
  logic [MdDataWidth-1:0] a_q, b_q, result_q;

  always_comb begin
    unique case (op_i)
      MD_OP_MULL, MD_OP_MULH: req_kind = KIND_MUL;
      MD_OP_DIV, MD_OP_REM:   req_kind = KIND_DIV;
      default:                req_kind = KIND_ALU;
    endcase
  end

  // requests while busy are dropped
  assign accept    = req_i && !busy_q;
  assign md_finish = (mult_en_q || div_en_q) && md_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      alu_pend_q <= 1'b0;
      mult_en_q  <= 1'b0;
      div_en_q   <= 1'b0;
      op_q       <= MD_OP_ADD;
      sign_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q     <= 1'b1;
        op_q       <= op_i;
        sign_q     <= sign_mode_i;
        mult_en_q  <= (req_kind == KIND_MUL);
        div_en_q   <= (req_kind == KIND_DIV);
        alu_pend_q <= (req_kind == KIND_ALU);
      end else if (alu_pend_q || md_finish) begin
        // enables drop the cycle after valid
        busy_q     <= 1'b0;
        done_q     <= 1'b1;
        alu_pend_q <= 1'b0;
        mult_en_q  <= 1'b0;
        div_en_q   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q <= op_a_i;
      b_q <= op_b_i;
    end
    if (alu_pend_q) begin
      result_q <= alu_result_i;
    end else if (md_finish) begin
      result_q <= md_result_i;
    end
  end

  assign mult_en_o   = mult_en_q;
  assign div_en_o    = div_en_q;
  assign operator_o  = op_q;
  assign sign_mode_o = sign_q;
  assign md_a_o      = a_q;
  assign md_b_o      = b_q;
  assign alu_op_o    = (op_q == MD_OP_SUB) ? ALU_SUB : ALU_ADD;
  assign alu_a_o     = a_q;
  assign alu_b_o     = b_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;
  assign result_o    = result_q;

endmodule

`default_nettype wire

/* src/md_top.sv */
// ====================
// arithmetic execution block, one request in flight
// req_i while idle starts work, done_o marks the result
// ====================
`default_nettype none

module md_top #(
  parameter int unsigned NumIter = 31
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  md_pkg::md_op_e                   op_i,
  input  md_pkg::sign_mode_t               sign_mode_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_a_i,
  input  logic [md_pkg::MdDataWidth-1:0]   op_b_i,
  output logic                             busy_o,
  output logic                             done_o,
  output logic [md_pkg::MdDataWidth-1:0]   result_o
);

  import md_pkg::*;
  import alu_pkg::*;

  logic                   mult_en, div_en;
  md_op_e                 operator;
  sign_mode_t             sign_mode;
  logic [MdDataWidth-1:0] md_a, md_b, md_result;
  logic                   md_valid;
  alu_op_e                alu_op;
  logic [MdDataWidth-1:0] alu_a, alu_b, alu_result;

  adder_if adder_bus ();

  md_issue i_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .op_i         (op_i),
    .sign_mode_i  (sign_mode_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .md_valid_i   (md_valid),
    .md_result_i  (md_result),
    .alu_result_i (alu_result),
    .mult_en_o    (mult_en),
    .div_en_o     (div_en),
    .operator_o   (operator),
    .sign_mode_o  (sign_mode),
    .md_a_o       (md_a),
    .md_b_o       (md_b),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .result_o     (result_o)
  );

  multdiv_slow #(
    .NumIter (NumIter)
  ) i_multdiv (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mult_en_i   (mult_en),
    .div_en_i    (div_en),
    .operator_i  (operator),
    .sign_mode_i (sign_mode),
    .op_a_i      (md_a),
    .op_b_i      (md_b),
    .adder_bus   (adder_bus),
    .result_o    (md_result),
    .valid_o     (md_valid)
  );

  // the adder follows the enables, so only one user at a time
  md_alu i_alu (
    .mult_en_i    (mult_en),
    .div_en_i     (div_en),
    .alu_op_i     (alu_op),
    .alu_a_i      (alu_a),
    .alu_b_i      (alu_b),
    .adder_bus    (adder_bus),
    .alu_result_o (alu_result)
  );

endmodule

`default_nettype wire

/* verification/tb_md_tests.svh */
// ====================
// directed tests and RV32M reference model for md_top,
// included inside the testbench module body
// ====================
`ifndef TB_MD_TESTS_SVH
`define TB_MD_TESTS_SVH

  // RV32M rules worked out in 64-bit arithmetic
  function automatic logic [31:0] expected_result(input md_op_e op, input sign_mode_t sm,
                                                  input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      wide;
    logic [31:0] res;
    sa = {{32{sm[0] & a[31]}}, a};
    sb = {{32{sm[1] & b[31]}}, b};
    wide = sa * sb;
    case (op)
      MD_OP_ADD:  res = a + b;
      MD_OP_SUB:  res = a - b;
      MD_OP_MULL: res = wide[31:0];
      MD_OP_MULH: res = wide[63:32];
      MD_OP_DIV: begin
        // zero divisor gives all ones
        if (b == 32'h0) begin
          res = 32'hffff_ffff;
        end else begin
          wide = sa / sb;
          res  = wide[31:0];
        end
      end
      default: begin
        if (b == 32'h0) begin
          res = a;
        end else begin
          wide = sa % sb;
          res  = wide[31:0];
        end
      end
    endcase
    return res;
  endfunction

  function automatic logic [31:0] edge_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // one request, then wait for done_o while busy_o must stay high
  task automatic issue_and_wait(input md_op_e op, input sign_mode_t sm,
                                input logic [31:0] a, input logic [31:0] b,
                                output int unsigned latency, output logic seen);
    int unsigned waited;
    @(posedge clk_i);
    req_i       <= 1'b1;
    op_i        <= op;
    sign_mode_i <= sm;
    op_a_i      <= a;
    op_b_i      <= b;
    @(posedge clk_i);
    req_i <= 1'b0;
    waited = 0;
    seen   = 1'b0;
    while (!seen && (waited < OpWaitLimit)) begin
      @(negedge clk_i);
      if (done_o) begin
        seen = 1'b1;
      end else begin
        waited++;
        if (busy_o !== 1'b1) begin
          error_count++;
          $display("MISMATCH busy_o during %s: got %0h expected 1", op.name(), busy_o);
        end
      end
    end
    latency = waited;
    if (!seen) begin
      error_count++;
      $display("no done_o within %0d cycles for %s", OpWaitLimit, op.name());
    end
  endtask

  task automatic check_op(input md_op_e op, input sign_mode_t sm,
                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] expected;
    int unsigned latency;
    logic        seen;
    expected = expected_result(op, sm, a, b);
    issue_and_wait(op, sm, a, b, latency, seen);
    if (seen) begin
      check_count++;
      if (result_o !== expected) begin
        error_count++;
        $display("MISMATCH result_o %s sm=%0h a=%08h b=%08h: got %08h expected %08h",
                 op.name(), sm, a, b, result_o, expected);
      end
      if (((op == MD_OP_ADD) || (op == MD_OP_SUB)) && (latency != 1)) begin
        error_count++;
        $display("MISMATCH done_o latency %s: got %0h expected 1", op.name(), latency);
      end
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_count++;
    if ((busy_o !== 1'b0) || (done_o !== 1'b0)) begin
      error_count++;
      $display("MISMATCH busy_o/done_o after reset: got %0h/%0h expected 0/0", busy_o, done_o);
    end
  endtask

  task automatic test_add_sub();
    for (int i = 0; i < 16; i++) begin
      check_op(MD_OP_ADD, 2'b00, next_random(), next_random());
      check_op(MD_OP_SUB, 2'b00, next_random(), next_random());
    end
  endtask

  // unsigned, signed-signed and signed-unsigned
  task automatic test_mul();
    sign_mode_t  modes [3];
    logic [31:0] a;
    logic [31:0] b;
    modes[0] = 2'b00;
    modes[1] = 2'b11;
    modes[2] = 2'b01;
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          check_op(MD_OP_MULL, modes[m], edge_value(i), edge_value(j));
          check_op(MD_OP_MULH, modes[m], edge_value(i), edge_value(j));
        end
      end
      for (int k = 0; k < 8; k++) begin
        a = next_random();
        b = next_random();
        check_op(MD_OP_MULL, modes[m], a, b);
        check_op(MD_OP_MULH, modes[m], a, b);
      end
    end
  endtask

  task automatic test_div_random();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 12; i++) begin
      a = next_random();
      b = next_random();
      // small divisors on odd steps so quotients get wide
      if (i % 2 == 1) begin
        b = $signed(b) >>> 20;
      end
      check_op(MD_OP_DIV, 2'b00, a, b);
      check_op(MD_OP_REM, 2'b00, a, b);
      check_op(MD_OP_DIV, 2'b11, a, b);
      check_op(MD_OP_REM, 2'b11, a, b);
    end
  endtask

  task automatic test_div_corners();
    logic [31:0] dividends [3];
    dividends[0] = next_random();
    dividends[1] = 32'h8000_0000;
    dividends[2] = 32'h7fff_ffff;
    for (int i = 0; i < 3; i++) begin
      check_op(MD_OP_DIV, 2'b00, dividends[i], 32'h0);
      check_op(MD_OP_REM, 2'b00, dividends[i], 32'h0);
      check_op(MD_OP_DIV, 2'b11, dividends[i], 32'h0);
      check_op(MD_OP_REM, 2'b11, dividends[i], 32'h0);
    end
    // signed overflow case, then the same bits unsigned
    check_op(MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    check_op(MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    check_op(MD_OP_DIV, 2'b00, 32'h8000_0000, 32'hffff_ffff);
    check_op(MD_OP_REM, 2'b00, 32'h8000_0000, 32'hffff_ffff);
  endtask

  // second request mid multiply must be dropped
  task automatic test_busy_ignore();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    int unsigned dones;
    a        = next_random();
    b        = next_random();
    expected = expected_result(MD_OP_MULL, 2'b11, a, b);
    @(posedge clk_i);
    req_i       <= 1'b1;
    op_i        <= MD_OP_MULL;
    sign_mode_i <= 2'b11;
    op_a_i      <= a;
    op_b_i      <= b;
    @(posedge clk_i);
    req_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    req_i       <= 1'b1;
    op_i        <= MD_OP_MULH;
    sign_mode_i <= 2'b00;
    op_a_i      <= ~a;
    op_b_i      <= b ^ 32'h5a5a_5a5a;
    @(posedge clk_i);
    req_i <= 1'b0;
    dones = 0;
    for (int i = 0; i < 80; i++) begin
      @(negedge clk_i);
      if (done_o) begin
        dones++;
        check_count++;
        if (result_o !== expected) begin
          error_count++;
          $display("MISMATCH result_o after ignored request: got %08h expected %08h",
                   result_o, expected);
        end
      end else if ((dones == 0) && (busy_o !== 1'b1)) begin
        error_count++;
        $display("MISMATCH busy_o before done_o: got %0h expected 1", busy_o);
      end
    end
    check_count++;
    if (dones != 1) begin
      error_count++;
      $display("MISMATCH done_o pulse count: got %0h expected 1", dones);
    end
  endtask

`endif

/* verification/tb_md_top.sv */
// ====================
// testbench for md_top, runs the directed tests from the
// included test header and prints one closing report
// ====================
`default_nettype none

module tb_md_top;

  import md_pkg::*;

  localparam int unsigned NumIter       = 31;
  // operations issued by the directed tests, the busy test counts as three
  localparam int unsigned NumOps        = 243;
  localparam int unsigned TimeoutCycles = 40 * NumOps + 400;
  // longest divide is 37 cycles after acceptance
  localparam int unsigned OpWaitLimit   = 64;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i;
  md_op_e                 op_i;
  sign_mode_t             sign_mode_i;
  logic [MdDataWidth-1:0] op_a_i;
  logic [MdDataWidth-1:0] op_b_i;
  logic                   busy_o;
  logic                   done_o;
  logic [MdDataWidth-1:0] result_o;

  int unsigned error_count;
  int unsigned check_count;
  int unsigned cycle_count;
  logic [31:0] rng_state;

  md_top #(
    .NumIter (NumIter)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .op_i        (op_i),
    .sign_mode_i (sign_mode_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .result_o    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // 32-bit xorshift, shift triple 13/17/5
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  `include "tb_md_tests.svh"

  // run limit sized from the number of operations
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout, run still going after %0d cycles", cycle_count);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    op_i        = MD_OP_ADD;
    sign_mode_i = 2'b00;
    op_a_i      = '0;
    op_b_i      = '0;
    error_count = 0;
    check_count = 0;
    rng_state   = 32'd42347;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset_state();
    test_add_sub();
    test_mul();
    test_div_random();
    test_div_corners();
    test_busy_ignore();

    @(posedge clk_i);
    $display("tb_md_top done, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
